// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert -Wall -Wno-fatal
TOP        = tb_poker_dealer
FILELIST   = project.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "failure reported in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== project.f ====
rtl/poker_pkg.sv
rtl/dealer_ctrl_pkg.sv
rtl/hand_sequencer.sv
rtl/card_router.sv
rtl/bank_keeper.sv
rtl/poker_dealer_top.sv
tests/dealer_asserts.sv
tests/tb_poker_dealer.sv

// ==== rtl/bank_keeper.sv ====
// holds both player banks and the pot; collects bets each round and pays the pot out at hand end
`timescale 1ns/1ps

module bank_keeper (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   game_over,
	input  logic                   new_hand,
	input  logic                   collect,
	input  logic                   payout,
	input  poker_pkg::bet_pair_t   bets,
	input  poker_pkg::outcome_t    winner,
	output poker_pkg::money_t      pot,
	output poker_pkg::bank_pair_t  banks
);

	poker_pkg::money_t half_pot;

	assign half_pot = pot >> 1; // split share rounds down

	// banks
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			banks.p1 <= poker_pkg::START_BANK;
			banks.p2 <= poker_pkg::START_BANK;
		end
		else if (game_over)
		begin
			banks.p1 <= poker_pkg::START_BANK;
			banks.p2 <= poker_pkg::START_BANK;
		end
		else if (collect)
		begin
			banks.p1 <= (banks.p1 > bets.p1) ? banks.p1 - bets.p1 : '0; // floor at zero
			banks.p2 <= (banks.p2 > bets.p2) ? banks.p2 - bets.p2 : '0;
		end
		else if (payout)
		begin
			case (winner)
				poker_pkg::player1:
				begin
					banks.p1 <= banks.p1 + pot;
				end
				poker_pkg::player2:
				begin
					banks.p2 <= banks.p2 + pot;
				end
				default:
				begin
					banks.p1 <= banks.p1 + half_pot;
					banks.p2 <= banks.p2 + half_pot;
				end
			endcase
		end
	end

	// pot keeps the full bets even past a short bank
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			pot <= '0;
		end
		else if (new_hand)
		begin
			pot <= '0;
		end
		else if (collect)
		begin
			pot <= pot + bets.p1 + bets.p2;
		end
	end

endmodule

// ==== rtl/card_router.sv ====
// requests cards for the current street and places each one into its hole or board slot
`timescale 1ns/1ps

module card_router (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    new_hand,
	input  logic                    deal_start,
	input  logic                    card_valid,
	input  poker_pkg::card_t        card_in,
	output logic                    card_req,
	output logic                    deal_done,
	output poker_pkg::hole_cards_t  hole,
	output poker_pkg::board_t       board
);

	logic [3:0] ptr;      // next slot with hole fields first then board
	logic [3:0] ptr_next;
	logic       busy;     // street in progress
	logic       street_end;

	assign ptr_next   = ptr + 4'd1;
	assign street_end = (ptr_next == poker_pkg::HOLE_CARDS) ||
		(ptr_next == poker_pkg::HOLE_CARDS + poker_pkg::FLOP_CARDS) ||
		(ptr_next == poker_pkg::HOLE_CARDS + poker_pkg::FLOP_CARDS + 1) ||
		(ptr_next == poker_pkg::HOLE_CARDS + poker_pkg::FLOP_CARDS + 2);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ptr       <= 4'd0;
			busy      <= 1'b0;
			card_req  <= 1'b0;
			deal_done <= 1'b0;
			hole      <= '{default: poker_pkg::CARD_NONE};
			board     <= '{default: poker_pkg::CARD_NONE};
		end
		else
		begin
			card_req  <= 1'b0;
			deal_done <= 1'b0;
			if (new_hand)
			begin
				ptr   <= 4'd0;
				busy  <= 1'b0;
				hole  <= '{default: poker_pkg::CARD_NONE};
				board <= '{default: poker_pkg::CARD_NONE};
			end
			else if (deal_start)
			begin
				busy     <= 1'b1;
				card_req <= 1'b1; // first card of the street
			end
			else if (busy && card_valid && ptr < 4'd9)
			begin
				case (ptr)
					4'd0: hole.p1_c1  <= card_in;
					4'd1: hole.p1_c2  <= card_in;
					4'd2: hole.p2_c1  <= card_in;
					4'd3: hole.p2_c2  <= card_in;
					4'd4: board.flop1 <= card_in;
					4'd5: board.flop2 <= card_in;
					4'd6: board.flop3 <= card_in;
					4'd7: board.turn  <= card_in;
					default: board.river <= card_in;
				endcase
				ptr <= ptr_next;
				if (street_end)
				begin
					busy      <= 1'b0;
					deal_done <= 1'b1;
				end
				else
				begin
					card_req <= 1'b1; // ask for the next one
				end
			end
		end
	end

endmodule

// ==== rtl/dealer_ctrl_pkg.sv ====
// state and street encodings of the hand sequencer, shared with its assertion module
package dealer_ctrl_pkg;

	typedef enum logic [3:0]
	{
		idle       = 4'd0,
		deal       = 4'd1, // start dealing a street
		deal_wait  = 4'd2,
		bet        = 4'd3, // open a betting round
		bet_wait   = 4'd4,
		collect    = 4'd5, // bets move into the pot
		check      = 4'd6,
		check_wait = 4'd7,
		payout     = 4'd8
	} hand_state_t;

	// one street per deal, bet and check pass
	typedef enum logic [1:0]
	{
		preflop = 2'd0,
		flop    = 2'd1,
		turn    = 2'd2,
		river   = 2'd3
	} street_t;

endpackage

// ==== rtl/hand_sequencer.sv ====
// per-hand FSM of the dealer; steps deal, bet, collect and check for each street, then payout
`timescale 1ns/1ps

module hand_sequencer (
	input  logic              clk,
	input  logic              rst,
	input  logic              next_hand,
	input  logic              deal_done,
	input  logic              bet_done,
	input  logic              check_done,
	input  logic              hand_over,
	output logic              new_hand,
	output logic              deal_start,
	output logic              bet_req,
	output logic              first_round,
	output logic              collect,
	output logic              check_req,
	output logic              payout,
	output logic              hand_done,
	output poker_pkg::seat_t  last_to_act
);

	dealer_ctrl_pkg::hand_state_t state;
	dealer_ctrl_pkg::street_t     street;
	poker_pkg::seat_t             dealer; // button seat

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state       <= dealer_ctrl_pkg::idle;
			street      <= dealer_ctrl_pkg::preflop;
			dealer      <= 1'b0;
			new_hand    <= 1'b0;
			deal_start  <= 1'b0;
			bet_req     <= 1'b0;
			first_round <= 1'b0;
			collect     <= 1'b0;
			check_req   <= 1'b0;
			payout      <= 1'b0;
			hand_done   <= 1'b0;
			last_to_act <= 1'b0;
		end
		else
		begin
			// pulses default low and only one state raises each
			new_hand   <= 1'b0;
			deal_start <= 1'b0;
			bet_req    <= 1'b0;
			collect    <= 1'b0;
			check_req  <= 1'b0;
			payout     <= 1'b0;
			hand_done  <= 1'b0;

			if (new_hand)
			begin
				dealer <= ~dealer; // button moves every hand
			end

			case (state)
				dealer_ctrl_pkg::idle:
				begin
					if (next_hand)
					begin
						new_hand <= 1'b1;
						street   <= dealer_ctrl_pkg::preflop;
						state    <= dealer_ctrl_pkg::deal;
					end
				end
				dealer_ctrl_pkg::deal:
				begin
					deal_start <= 1'b1;
					state      <= dealer_ctrl_pkg::deal_wait;
				end
				dealer_ctrl_pkg::deal_wait:
				begin
					if (deal_done)
					begin
						state <= dealer_ctrl_pkg::bet;
					end
				end
				dealer_ctrl_pkg::bet:
				begin
					bet_req <= 1'b1;
					// non-dealer closes preflop and dealer closes later streets
					if (street == dealer_ctrl_pkg::preflop)
					begin
						first_round <= 1'b1;
						last_to_act <= ~dealer;
					end
					else
					begin
						last_to_act <= dealer;
					end
					state <= dealer_ctrl_pkg::bet_wait;
				end
				dealer_ctrl_pkg::bet_wait:
				begin
					if (bet_done)
					begin
						collect <= 1'b1; // banks and pot update on the next edge
						state   <= dealer_ctrl_pkg::collect;
					end
				end
				dealer_ctrl_pkg::collect:
				begin
					first_round <= 1'b0;
					state       <= dealer_ctrl_pkg::check;
				end
				dealer_ctrl_pkg::check:
				begin
					check_req <= 1'b1;
					state     <= dealer_ctrl_pkg::check_wait;
				end
				dealer_ctrl_pkg::check_wait:
				begin
					if (check_done)
					begin
						if (hand_over || street == dealer_ctrl_pkg::river)
						begin
							payout <= 1'b1;
							state  <= dealer_ctrl_pkg::payout;
						end
						else
						begin
							street <= dealer_ctrl_pkg::street_t'(street + 2'd1);
							state  <= dealer_ctrl_pkg::deal;
						end
					end
				end
				dealer_ctrl_pkg::payout:
				begin
					hand_done <= 1'b1; // rises with the bank write
					state     <= dealer_ctrl_pkg::idle;
				end
				default:
				begin
					state <= dealer_ctrl_pkg::idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/poker_dealer_top.sv ====
// top of the hold'em dealer; connects the hand sequencer, card router and bank keeper
`timescale 1ns/1ps

module poker_dealer_top (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    next_hand,
	input  logic                    game_over,
	input  poker_pkg::card_t        card_in,
	input  logic                    card_valid,
	output logic                    card_req,
	input  poker_pkg::bet_pair_t    bets,
	input  logic                    bet_done,
	output logic                    bet_req,
	output logic                    first_round,
	output poker_pkg::seat_t        last_to_act,
	input  logic                    check_done,
	input  logic                    hand_over,
	input  poker_pkg::outcome_t     winner,
	output logic                    check_req,
	output poker_pkg::hole_cards_t  hole,
	output poker_pkg::board_t       board,
	output poker_pkg::money_t       pot,
	output poker_pkg::bank_pair_t   banks,
	output logic                    hand_done
);

	logic new_hand;   // clears cards and pot
	logic deal_start;
	logic deal_done;
	logic collect;
	logic payout;

	hand_sequencer i_hand_sequencer (
		.clk         (clk),
		.rst         (rst),
		.next_hand   (next_hand),
		.deal_done   (deal_done),
		.bet_done    (bet_done),
		.check_done  (check_done),
		.hand_over   (hand_over),
		.new_hand    (new_hand),
		.deal_start  (deal_start),
		.bet_req     (bet_req),
		.first_round (first_round),
		.collect     (collect),
		.check_req   (check_req),
		.payout      (payout),
		.hand_done   (hand_done),
		.last_to_act (last_to_act)
	);

	card_router i_card_router (
		.clk        (clk),
		.rst        (rst),
		.new_hand   (new_hand),
		.deal_start (deal_start),
		.card_valid (card_valid),
		.card_in    (card_in),
		.card_req   (card_req),
		.deal_done  (deal_done),
		.hole       (hole),
		.board      (board)
	);

	bank_keeper i_bank_keeper (
		.clk       (clk),
		.rst       (rst),
		.game_over (game_over),
		.new_hand  (new_hand),
		.collect   (collect),
		.payout    (payout),
		.bets      (bets),
		.winner    (winner),
		.pot       (pot),
		.banks     (banks)
	);

endmodule

// ==== rtl/poker_pkg.sv ====
// card, money and seat types plus game constants shared by the dealer RTL and its testbench
package poker_pkg;

	// card encoding with the suit in the top 2 bits and the value in the low 4
	typedef logic [5:0] card_t;
	typedef logic [7:0] money_t; // betting units
	typedef logic       seat_t;  // 0 is player 1 and 1 is player 2

	// result of a winner check as the evaluator reports it
	typedef enum logic [1:0]
	{
		none    = 2'b00,
		player1 = 2'b01,
		player2 = 2'b10,
		draw    = 2'b11
	} outcome_t;

	typedef struct packed
	{
		card_t p1_c1;
		card_t p1_c2;
		card_t p2_c1;
		card_t p2_c2;
	} hole_cards_t; // dealt in field order

	typedef struct packed
	{
		card_t flop1;
		card_t flop2;
		card_t flop3;
		card_t turn;
		card_t river;
	} board_t;

	typedef struct packed
	{
		money_t p1;
		money_t p2;
	} bet_pair_t; // one betting round

	typedef struct packed
	{
		money_t p1;
		money_t p2;
	} bank_pair_t;

	localparam card_t       CARD_NONE  = 6'd0;
	localparam money_t      START_BANK = 8'd64;  // after reset and game over
	localparam int unsigned HOLE_CARDS = 4;      // first street
	localparam int unsigned FLOP_CARDS = 3;

endpackage

// ==== tests/dealer_asserts.sv ====
// protocol checks on the hand sequencer; attached to every sequencer instance by the bind below
`timescale 1ns/1ps

module dealer_asserts (
	input logic                          clk,
	input logic                          rst,
	input dealer_ctrl_pkg::hand_state_t  state,
	input logic                          bet_done,
	input logic                          bet_req,
	input logic                          collect,
	input logic                          check_req,
	input logic                          hand_done
);

	bet_req_pulse: assert property (@(posedge clk) disable iff (!rst) bet_req |=> !bet_req)
		else $error("bet_req high for more than one cycle");

	check_req_pulse: assert property (@(posedge clk) disable iff (!rst) check_req |=> !check_req)
		else $error("check_req high for more than one cycle");

	hand_done_pulse: assert property (@(posedge clk) disable iff (!rst) hand_done |=> !hand_done)
		else $error("hand_done high for more than one cycle");

	// an awaited bet_done is collected on the next cycle and only then
	collect_follows: assert property (@(posedge clk) disable iff (!rst)
		(state == dealer_ctrl_pkg::bet_wait && bet_done) |=> collect)
		else $error("collect did not follow bet_done");

	collect_cause: assert property (@(posedge clk) disable iff (!rst) collect |-> $past(bet_done))
		else $error("collect without bet_done one cycle before");

	no_check_in_deal: assert property (@(posedge clk) disable iff (!rst)
		(state == dealer_ctrl_pkg::deal_wait) |-> !check_req)
		else $error("check_req issued while dealing");

endmodule

bind hand_sequencer dealer_asserts i_dealer_asserts (
	.clk       (clk),
	.rst       (rst),
	.state     (state),
	.bet_done  (bet_done),
	.bet_req   (bet_req),
	.collect   (collect),
	.check_req (check_req),
	.hand_done (hand_done)
);

// ==== tests/hand_golden.txt ====
// per hand: cards c0..c8, bets p1 p2 for rounds 0..3, hand_over 0..3, winner 0..3,
// game_over flag, expected banks p1 p2 at hand_done; all values are hex bytes
0e 1d 22 33 05 16 27 38 09 02 02 04 04 04 04 08 08 00 00 00 00 00 00 00 01 00 52 2e
11 2c 3a 04 1b 25 36 07 18 03 03 05 05 00 00 00 00 00 01 00 00 00 02 00 00 00 4a 36
3e 2e 1e 0e 02 13 24 35 06 03 04 00 00 00 00 00 00 01 00 00 00 03 00 00 00 00 4a 35
0c 1c 2c 3c 03 14 25 36 07 10 30 08 08 00 00 00 00 00 00 00 00 00 00 00 02 01 32 50
21 32 03 14 25 36 07 18 29 01 01 02 02 03 03 00 00 00 00 01 00 00 00 01 00 00 46 3a
0a 1b 2c 3d 0e 1f 2a 31 02 05 05 05 05 05 05 05 05 00 00 00 00 00 00 00 00 01 46 3a

// ==== tests/tb_poker_dealer.sv ====
// testbench for the hold'em dealer; plays every hand of the golden file and checks the DUT
`timescale 1ns/1ps

module tb_poker_dealer;

	localparam int unsigned N_HANDS  = 6;
	localparam int unsigned WORDS    = 28;  // bytes per golden line
	localparam int unsigned TIMEOUT  = 100; // cycles allowed per wait
	localparam int unsigned OFS_BET  = 9;   // offsets inside one golden line
	localparam int unsigned OFS_OVER = 17;
	localparam int unsigned OFS_WIN  = 21;
	localparam int unsigned OFS_GO   = 25;
	localparam int unsigned OFS_BANK = 26;
	localparam int SEL_CARD  = 0;
	localparam int SEL_BET   = 1;
	localparam int SEL_CHECK = 2;
	localparam int SEL_DONE  = 3;

	logic                   clk;
	logic                   rst;
	logic                   next_hand;
	logic                   game_over;
	poker_pkg::card_t       card_in;
	logic                   card_valid;
	logic                   card_req;
	poker_pkg::bet_pair_t   bets;
	logic                   bet_done;
	logic                   bet_req;
	logic                   first_round;
	poker_pkg::seat_t       last_to_act;
	logic                   check_done;
	logic                   hand_over;
	poker_pkg::outcome_t    winner;
	logic                   check_req;
	poker_pkg::hole_cards_t hole;
	poker_pkg::board_t      board;
	poker_pkg::money_t      pot;
	poker_pkg::bank_pair_t  banks;
	logic                   hand_done;

	logic [7:0]            gold [0:N_HANDS*WORDS-1];
	int unsigned           errors;
	int unsigned           checks;
	int unsigned           h;
	logic                  stop;       // set when a wait runs out
	poker_pkg::bank_pair_t bank_exp;
	poker_pkg::seat_t      dealer_exp; // button seat of the current hand
	string                 slot_name [9] = '{"hole.p1_c1", "hole.p1_c2", "hole.p2_c1",
		"hole.p2_c2", "board.flop1", "board.flop2", "board.flop3", "board.turn", "board.river"};

	poker_dealer_top i_dut (.*);

	always #10 clk = ~clk;

	function automatic logic req_high(input int sel);
		case (sel)
			SEL_CARD:  return card_req;
			SEL_BET:   return bet_req;
			SEL_CHECK: return check_req;
			default:   return hand_done;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("Mismatch %s expected 0x%0h actual 0x%0h", name, exp, act);
		end
	endtask

	// polls at falling edges starting with the current one
	task automatic wait_for(input int sel, input string what);
		int unsigned n;
		n = 0;
		while (!stop && !req_high(sel) && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!stop && !req_high(sel))
		begin
			stop = 1'b1;
			$display("timeout waiting for %s", what);
		end
	endtask

	// responder latency of 1 to 4 cycles
	task automatic answer_delay(input int sel, input string what);
		int unsigned d;
		d = $urandom_range(4, 1);
		@(negedge clk);
		checks++;
		assert (!req_high(sel))
		else
		begin
			errors++;
			$display("%s stayed high for more than one cycle", what);
		end
		repeat (d - 1) @(negedge clk);
	endtask

	task automatic check_reset();
		check_val("banks.p1", poker_pkg::START_BANK, banks.p1);
		check_val("banks.p2", poker_pkg::START_BANK, banks.p2);
		check_val("pot", 0, pot);
		check_val("hole", 0, hole);
		check_val("board", 0, board);
		check_val("card_req", 0, card_req);
		check_val("bet_req", 0, bet_req);
		check_val("check_req", 0, check_req);
		check_val("hand_done", 0, hand_done);
		$display("reset values done, %0d errors so far", errors);
	endtask

	task automatic play_hand(input int unsigned hand);
		int unsigned          base;
		int unsigned          idx;
		int unsigned          s;
		int unsigned          c;
		int unsigned          n_cards;
		logic                 over;
		poker_pkg::money_t    pot_exp;
		poker_pkg::seat_t     seat_exp;
		poker_pkg::bet_pair_t bet;
		poker_pkg::card_t     fed [0:8];
		logic [53:0]          slots;
		base    = hand * WORDS;
		idx     = 0;
		over    = 1'b0;
		pot_exp = '0;
		for (c = 0; c < 9; c++)
			fed[c] = poker_pkg::CARD_NONE; // undealt slots must stay empty
		dealer_exp = ~dealer_exp;
		next_hand  = 1'b1;
		@(negedge clk);
		next_hand = 1'b0;
		for (s = 0; s < 4 && !over; s++)
		begin
			n_cards = (s == 0) ? poker_pkg::HOLE_CARDS : (s == 1) ? poker_pkg::FLOP_CARDS : 1;
			for (c = 0; c < n_cards; c++)
			begin
				wait_for(SEL_CARD, "card_req");
				if (stop)
					return;
				answer_delay(SEL_CARD, "card_req");
				fed[idx]   = gold[base + idx][5:0];
				card_in    = fed[idx];
				card_valid = 1'b1;
				@(negedge clk);
				card_valid = 1'b0;
				card_in    = poker_pkg::CARD_NONE;
				idx++;
			end
			wait_for(SEL_BET, "bet_req");
			if (stop)
				return;
			seat_exp = (s == 0) ? ~dealer_exp : dealer_exp; // non-dealer closes preflop only
			check_val("first_round", (s == 0), first_round);
			check_val("last_to_act", seat_exp, last_to_act);
			bet.p1 = gold[base + OFS_BET + 2*s];
			bet.p2 = gold[base + OFS_BET + 2*s + 1];
			answer_delay(SEL_BET, "bet_req");
			bets     = bet;
			bet_done = 1'b1;
			@(negedge clk);
			bet_done    = 1'b0;
			bank_exp.p1 = (bet.p1 >= bank_exp.p1) ? 8'd0 : bank_exp.p1 - bet.p1;
			bank_exp.p2 = (bet.p2 >= bank_exp.p2) ? 8'd0 : bank_exp.p2 - bet.p2;
			pot_exp     = pot_exp + bet.p1 + bet.p2; // full bets even from a short bank
			wait_for(SEL_CHECK, "check_req");
			if (stop)
				return;
			check_val("pot", pot_exp, pot);
			check_val("banks.p1", bank_exp.p1, banks.p1);
			check_val("banks.p2", bank_exp.p2, banks.p2);
			answer_delay(SEL_CHECK, "check_req");
			hand_over  = gold[base + OFS_OVER + s][0];
			winner     = poker_pkg::outcome_t'(gold[base + OFS_WIN + s][1:0]);
			check_done = 1'b1;
			@(negedge clk);
			check_done = 1'b0;
			over       = hand_over || (s == 3);
		end
		wait_for(SEL_DONE, "hand_done");
		if (stop)
			return;
		if (winner == poker_pkg::player1)
			bank_exp.p1 = bank_exp.p1 + pot_exp;
		else if (winner == poker_pkg::player2)
			bank_exp.p2 = bank_exp.p2 + pot_exp;
		else
		begin
			bank_exp.p1 = bank_exp.p1 + pot_exp / 2; // split rounds down
			bank_exp.p2 = bank_exp.p2 + pot_exp / 2;
		end
		check_val("banks.p1", bank_exp.p1, banks.p1);
		check_val("banks.p2", bank_exp.p2, banks.p2);
		check_val("banks.p1 vs golden", gold[base + OFS_BANK], banks.p1);
		check_val("banks.p2 vs golden", gold[base + OFS_BANK + 1], banks.p2);
		slots = {hole, board};
		for (c = 0; c < 9; c++)
			check_val(slot_name[c], fed[c], slots[53 - 6*c -: 6]);
		if (gold[base + OFS_GO][0])
		begin
			game_over = 1'b1;
			@(negedge clk);
			game_over = 1'b0;
			bank_exp  = {poker_pkg::START_BANK, poker_pkg::START_BANK};
			check_val("banks.p1", bank_exp.p1, banks.p1);
			check_val("banks.p2", bank_exp.p2, banks.p2);
		end
		$display("hand %0d done: banks 0x%0h 0x%0h, pot 0x%0h, %0d errors so far",
			hand, banks.p1, banks.p2, pot, errors);
	endtask

	initial
	begin
		clk        = 1'b0;
		rst        = 1'b0;
		next_hand  = 1'b0;
		game_over  = 1'b0;
		card_in    = poker_pkg::CARD_NONE;
		card_valid = 1'b0;
		bets       = '0;
		bet_done   = 1'b0;
		check_done = 1'b0;
		hand_over  = 1'b0;
		winner     = poker_pkg::none;
		errors     = 0;
		checks     = 0;
		stop       = 1'b0;
		dealer_exp = 1'b0;
		bank_exp   = {poker_pkg::START_BANK, poker_pkg::START_BANK};
		void'($urandom(32'h6d5f));
		$readmemh("tests/hand_golden.txt", gold);
		checks++;
		assert (!$isunknown(gold[N_HANDS*WORDS-1]))
		else
		begin
			errors++;
			$display("golden file holds fewer than %0d complete hands", N_HANDS);
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		check_reset();
		for (h = 0; h < N_HANDS && !stop; h++)
			play_hand(h);
		$display("%0d hands, %0d checks, %0d errors", h, checks, errors);
		if (errors == 0 && !stop)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
